// ==== src.f ====
hw/rv_exec_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/shift_counter.sv
hw/serial_shifter.sv
hw/exec_ctrl.sv
hw/exec_unit.sv
sim/exec_unit_properties.sv
sim/tb_exec_unit.sv

// ==== sim/tb_exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exec_unit;
  import rv_exec_pkg::*;

  localparam int NUM_REGS = 32;
  localparam int N_ALU    = 60;
  localparam int N_SHIFT  = 40;
  localparam int N_BAD    = 12;
  localparam int N_INSTR  = 2 * NUM_REGS + N_ALU + N_SHIFT + 2 * N_BAD + 2;
  localparam int TIMEOUT_CYCLES = 40 * N_INSTR;

  logic     clk;
  logic     arst_n;
  logic     instr_valid;
  word_t    instr;
  logic     instr_ready;
  logic     flush;
  logic     result_valid;
  reg_idx_t rd_idx;
  word_t    rd_val;
  logic     illegal;

  integer   seed;
  int       edge_count;
  word_t    model_regs [NUM_REGS];
  word_t    exp_val_q [$];
  reg_idx_t exp_rd_q [$];
  logic     exp_ill_q [$];
  int       acc_at_q [$];  // Edge count of the accepting edge
  int       exp_at_q [$];  // Edge count when the pulse is due

  exec_unit #(.NUM_REGS(NUM_REGS)) dut0 (
    .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
    .instr_ready(instr_ready), .flush(flush), .result_valid(result_valid),
    .rd_idx(rd_idx), .rd_val(rd_val), .illegal(illegal)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    edge_count <= edge_count + 1;
    if (edge_count >= TIMEOUT_CYCLES) begin
      stop_run("Timeout: the run went past its cycle limit");
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  function automatic word_t encode_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input funct3_t f3,
                                     input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input funct3_t f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  // RV32I OP / OP-IMM semantics on the model registers, with latency in edges
  function automatic word_t ref_exec(input word_t w, output logic ill, output int lat);
    logic [6:0] f7;
    funct3_t    f3;
    word_t      a;
    word_t      b;
    word_t      res;
    logic       two_ok;
    f7     = w[31:25];
    f3     = w[14:12];
    a      = model_regs[w[19:15]];
    two_ok = (f7 == 7'h00) || (f7 == 7'h20);
    lat    = 1;
    res    = '0;
    if (w[6:0] == OPC_OP) begin
      b   = model_regs[w[24:20]];
      ill = (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) ? !two_ok : (f7 != 7'h00);
      ill = ill || (int'(w[24:20]) >= NUM_REGS);
    end else if (w[6:0] == OPC_OP_IMM) begin
      b   = {{20{w[31]}}, w[31:20]};
      ill = (f3 == F3_SLL) ? (f7 != 7'h00) : ((f3 == F3_SRL_SRA) ? !two_ok : 1'b0);
    end else begin
      b   = '0;
      ill = 1'b1;
    end
    ill = ill || (int'(w[11:7]) >= NUM_REGS) || (int'(w[19:15]) >= NUM_REGS);
    if (!ill) begin
      case (f3)
        F3_ADD_SUB: res = (w[6:0] == OPC_OP && f7[5]) ? a - b : a + b;
        F3_SLT:     res = {31'b0, $signed(a) < $signed(b)};
        F3_SLTU:    res = {31'b0, a < b};
        F3_XOR:     res = a ^ b;
        F3_OR:      res = a | b;
        F3_AND:     res = a & b;
        F3_SLL: begin
          res = a << b[4:0];
          lat = int'(b[4:0]) + 2;
        end
        F3_SRL_SRA: begin
          res = f7[5] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
          lat = int'(b[4:0]) + 2;
        end
      endcase
    end
    return res;
  endfunction

  // Hold the word until accepted; track adds the expected result
  task automatic send(input word_t w, input logic track);
    word_t val;
    logic  ill;
    int    lat;
    val = ref_exec(w, ill, lat);
    @(negedge clk);
    instr       = w;
    instr_valid = 1'b1;
    #1;
    while (!instr_ready) begin
      @(negedge clk);
      #1;
    end
    if (track) begin
      exp_val_q.push_back(val);
      exp_rd_q.push_back(w[11:7]);
      exp_ill_q.push_back(ill);
      acc_at_q.push_back(edge_count + 1);
      exp_at_q.push_back(edge_count + lat);
      if (!ill && w[11:7] != 5'd0) begin
        model_regs[w[11:7]] = val;
      end
    end
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = $random(seed);  // Junk while idle
  endtask

  task automatic run_instr(input word_t w);
    send(w, 1'b1);
    while (exp_at_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  always @(negedge clk) begin
    #5;
    if (exp_at_q.size() != 0 && edge_count >= acc_at_q[0]) begin
      check_flag(instr_ready, 1'b0, "instr_ready while busy");
    end
    if (exp_at_q.size() != 0 && edge_count == exp_at_q[0]) begin
      if (!result_valid) begin
        stop_run("Error: the expected result pulse did not arrive in time");
      end
      check_idx(rd_idx, exp_rd_q[0], "rd_idx");
      check_flag(illegal, exp_ill_q[0], "illegal");
      if (!exp_ill_q[0]) begin
        check_word(rd_val, exp_val_q[0], "rd_val");
      end
      void'(exp_val_q.pop_front());
      void'(exp_rd_q.pop_front());
      void'(exp_ill_q.pop_front());
      void'(acc_at_q.pop_front());
      void'(exp_at_q.pop_front());
    end else if (result_valid) begin
      stop_run("Error: a result pulse came with no instruction waiting for it");
    end
  end

  initial begin
    word_t      w;
    reg_idx_t   ra;
    reg_idx_t   rb;
    reg_idx_t   rc;
    funct3_t    f3;
    logic [6:0] f7;
    logic [11:0] imm;
    shamt_t     sh;
    seed        = 63548;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    flush       = 1'b0;
    edge_count  = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Load through ADDI, then read back with ADD rd, rd, x0
    imm = $random(seed);
    run_instr(encode_i(imm, 5'd0, F3_ADD_SUB, 5'd0));
    for (int i = 1; i < NUM_REGS; i++) begin
      imm = $random(seed);
      run_instr(encode_i(imm, 5'd0, F3_ADD_SUB, reg_idx_t'(i)));
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      run_instr(encode_r(7'h00, 5'd0, reg_idx_t'(i), F3_ADD_SUB, reg_idx_t'(i)));
    end

    for (int i = 0; i < N_ALU; i++) begin
      ra  = $random(seed);
      rb  = $random(seed);
      rc  = $random(seed);
      imm = $random(seed);
      f3  = $random(seed);
      if (f3 == F3_SLL) f3 = F3_SLT;
      if (f3 == F3_SRL_SRA) f3 = F3_AND;
      f7 = (f3 == F3_ADD_SUB && ($random(seed) & 1)) ? 7'h20 : 7'h00;
      w  = (i % 2) ? encode_r(f7, rb, ra, f3, rc) : encode_i(imm, ra, f3, rc);
      run_instr(w);
    end

    for (int i = 0; i < N_SHIFT; i++) begin
      ra = $random(seed);
      rb = $random(seed);
      rc = $random(seed);
      sh = $random(seed);
      f3 = ($random(seed) & 1) ? F3_SLL : F3_SRL_SRA;
      f7 = (f3 == F3_SRL_SRA && ($random(seed) & 1)) ? 7'h20 : 7'h00;
      w  = (i % 2) ? encode_r(f7, rb, ra, f3, rc) : encode_i({f7, sh}, ra, f3, rc);
      run_instr(w);
    end

    // Illegal words, each followed by a readback of its rd
    for (int i = 0; i < N_BAD; i++) begin
      ra = $random(seed);
      rb = $random(seed);
      rc = $random(seed);
      sh = $random(seed);
      if (rc == 5'd0) rc = 5'd1;
      case (i % 4)
        0:       w = encode_r(7'h01, rb, ra, F3_ADD_SUB, rc);
        1:       w = encode_r(7'h20, rb, ra, F3_OR, rc);
        2:       w = encode_i({7'h20, sh}, ra, F3_SLL, rc);
        default: begin
          w       = $random(seed);
          w[6:0]  = (i % 8 == 3) ? 7'b1100011 : 7'b0000011;  // Branch or load
          w[11:7] = rc;
        end
      endcase
      run_instr(w);
      run_instr(encode_r(7'h00, 5'd0, rc, F3_ADD_SUB, rc));
    end

    // Long SLLI into x9, dropped part way
    send(encode_i({7'h00, 5'd31}, 5'd7, F3_SLL, 5'd9), 1'b0);
    repeat (6) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    repeat (40) @(negedge clk);
    run_instr(encode_r(7'h00, 5'd0, 5'd9, F3_ADD_SUB, 5'd9));

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/exec_unit_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit_properties (
  input logic                     clk,
  input logic                     arst_n,
  input rv_exec_pkg::exec_state_t state,
  input logic                     flush,
  input logic                     instr_valid,
  input logic                     instr_ready,
  input logic                     illegal_in,
  input logic                     result_valid,
  input logic                     wr_en,
  input logic                     illegal_out
);
  import rv_exec_pkg::*;

  a_busy_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
    (instr_valid && instr_ready) |=> !instr_ready)
    else $error("instr_ready still high after an accepted instruction");

  a_result_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |=> !result_valid)
    else $error("result_valid longer than one cycle");

  // Decoder flag is held until the pulse and blocks the write
  a_no_illegal_write: assert property (@(posedge clk) disable iff (!arst_n)
    (instr_valid && instr_ready && illegal_in) |=> (result_valid && illegal_out && !wr_en))
    else $error("register write for an illegal instruction");

  // Flushed shift returns to IDLE and never reaches DONE
  a_flush_no_result: assert property (@(posedge clk) disable iff (!arst_n)
    (state == SHIFT && flush) |=> !result_valid)
    else $error("result pulse after a flushed shift");

endmodule

bind exec_ctrl exec_unit_properties u_props (
  .clk(clk), .arst_n(arst_n), .state(state), .flush(flush), .instr_valid(instr_valid),
  .instr_ready(instr_ready), .illegal_in(illegal), .result_valid(result_valid),
  .wr_en(wr_en), .illegal_out(illegal_out)
);

`default_nettype wire

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  instr_valid,
  input  rv_exec_pkg::word_t    instr,
  output logic                  instr_ready,
  input  logic                  flush,
  output logic                  result_valid,
  output rv_exec_pkg::reg_idx_t rd_idx,
  output rv_exec_pkg::word_t    rd_val,
  output logic                  illegal
);
  import rv_exec_pkg::*;

  reg_idx_t dec_rs1;
  reg_idx_t dec_rs2;
  reg_idx_t dec_rd;
  funct3_t  dec_funct3;
  logic     dec_alt;
  word_t    dec_imm;
  logic     dec_is_imm;
  logic     dec_is_shift;
  logic     dec_illegal;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_rhs;
  word_t    alu_value;
  word_t    shifted;
  logic     wr_en;
  logic     ctr_load;
  logic     ctr_dec;
  logic     count_zero;
  logic     sh_load;
  logic     sh_step;
  logic     sh_left;
  logic     sh_arith;

  instr_decoder #(.NUM_REGS(NUM_REGS)) u_dec (
    .instr(instr), .rs1_idx(dec_rs1), .rs2_idx(dec_rs2), .rd_idx(dec_rd),
    .funct3(dec_funct3), .alt(dec_alt), .imm(dec_imm), .is_imm(dec_is_imm),
    .is_shift(dec_is_shift), .illegal(dec_illegal)
  );

  reg_file #(.NUM_REGS(NUM_REGS)) u_rf (
    .clk(clk), .arst_n(arst_n), .rs1_idx(dec_rs1), .rs2_idx(dec_rs2),
    .wr_idx(rd_idx), .wr_en(wr_en), .wr_data(rd_val),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu u_alu (
    .funct3(dec_funct3), .alt(dec_alt), .lhs(rs1_data), .rhs(alu_rhs), .value(alu_value)
  );

  // Shift distance is the low five bits of the second operand
  shift_counter u_cnt (
    .clk(clk), .arst_n(arst_n), .load(ctr_load), .dec(ctr_dec),
    .shamt(alu_rhs[4:0]), .count_zero(count_zero)
  );

  serial_shifter u_shf (
    .clk(clk), .arst_n(arst_n), .load(sh_load), .step(sh_step), .left(sh_left),
    .arith(sh_arith), .din(rs1_data), .dout(shifted)
  );

  exec_ctrl u_ctrl (
    .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .flush(flush),
    .rd_idx(dec_rd), .funct3(dec_funct3), .alt(dec_alt), .imm(dec_imm),
    .is_imm(dec_is_imm), .is_shift(dec_is_shift), .illegal(dec_illegal),
    .rs2_data(rs2_data), .alu_value(alu_value), .shifted(shifted),
    .count_zero(count_zero), .instr_ready(instr_ready), .result_valid(result_valid),
    .illegal_out(illegal), .rd_out(rd_idx), .rd_val(rd_val), .wr_en(wr_en),
    .alu_rhs(alu_rhs), .ctr_load(ctr_load), .ctr_dec(ctr_dec), .sh_load(sh_load),
    .sh_step(sh_step), .sh_left(sh_left), .sh_arith(sh_arith)
  );

endmodule

`default_nettype wire

// ==== hw/exec_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_ctrl (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  instr_valid,
  input  logic                  flush,
  input  rv_exec_pkg::reg_idx_t rd_idx,
  input  rv_exec_pkg::funct3_t  funct3,
  input  logic                  alt,
  input  rv_exec_pkg::word_t    imm,
  input  logic                  is_imm,
  input  logic                  is_shift,
  input  logic                  illegal,
  input  rv_exec_pkg::word_t    rs2_data,
  input  rv_exec_pkg::word_t    alu_value,
  input  rv_exec_pkg::word_t    shifted,
  input  logic                  count_zero,
  output logic                  instr_ready,
  output logic                  result_valid,
  output logic                  illegal_out,
  output rv_exec_pkg::reg_idx_t rd_out,
  output rv_exec_pkg::word_t    rd_val,
  output logic                  wr_en,
  output rv_exec_pkg::word_t    alu_rhs,
  output logic                  ctr_load,
  output logic                  ctr_dec,
  output logic                  sh_load,
  output logic                  sh_step,
  output logic                  sh_left,
  output logic                  sh_arith
);
  import rv_exec_pkg::*;

  exec_state_t state;
  exec_state_t state_nxt;

  logic     accept;
  logic     start_shift;
  logic     shift_run;   // One bit moves this cycle
  logic     shift_end;   // Last bit done, leave SHIFT
  reg_idx_t rd_q;
  word_t    val_q;
  logic     illegal_q;
  logic     left_q;
  logic     arith_q;

  assign alu_rhs = is_imm ? imm : rs2_data;  // Second operand mux

  assign instr_ready = (state == IDLE) && !flush;
  assign accept      = instr_valid && instr_ready;
  assign start_shift = accept && is_shift && !illegal;

  assign shift_run = (state == SHIFT) && !flush && !count_zero;
  assign shift_end = (state == SHIFT) && !flush && count_zero;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start_shift) begin
          state_nxt = SHIFT;
        end else if (accept) begin
          state_nxt = DONE;  // Single-step or illegal
        end
      end
      SHIFT: begin
        if (flush) begin
          state_nxt = IDLE;  // Drop the shift, no result
        end else if (count_zero) begin
          state_nxt = DONE;
        end
      end
      DONE:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      illegal_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        illegal_q <= illegal;
      end
    end
  end

  // Destination, direction and result value
  always_ff @(posedge clk) begin
    if (accept) begin
      rd_q    <= rd_idx;
      left_q  <= (funct3 == F3_SLL);
      arith_q <= alt;
      val_q   <= illegal ? '0 : alu_value;
    end else if (shift_end) begin
      val_q <= shifted;
    end
  end

  assign ctr_load = start_shift;
  assign sh_load  = start_shift;
  assign ctr_dec  = shift_run;
  assign sh_step  = shift_run;
  assign sh_left  = left_q;
  assign sh_arith = arith_q;

  assign result_valid = (state == DONE);
  assign wr_en        = (state == DONE) && !illegal_q;  // Write lands at exit of DONE
  assign illegal_out  = illegal_q;
  assign rd_out       = rd_q;
  assign rd_val       = val_q;

endmodule

`default_nettype wire

// ==== hw/serial_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module serial_shifter (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               load,
  input  logic               step,
  input  logic               left,
  input  logic               arith,
  input  rv_exec_pkg::word_t din,
  output rv_exec_pkg::word_t dout
);
  import rv_exec_pkg::*;

  word_t sh_q;
  logic  fill;  // Bit entering at the top on a right shift

  assign fill = arith & sh_q[31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sh_q <= '0;
    end else if (load) begin
      sh_q <= din;
    end else if (step) begin
      if (left) begin
        sh_q <= {sh_q[30:0], 1'b0};
      end else begin
        sh_q <= {fill, sh_q[31:1]};
      end
    end
  end

  assign dout = sh_q;

endmodule

`default_nettype wire

// ==== hw/shift_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module shift_counter (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                load,
  input  logic                dec,
  input  rv_exec_pkg::shamt_t shamt,
  output logic                count_zero
);
  import rv_exec_pkg::*;

  shamt_t count;  // Bits still to shift

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (load) begin
      count <= shamt;
    end else if (dec && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign count_zero = (count == '0);

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  rv_exec_pkg::funct3_t funct3,
  input  logic                 alt,
  input  rv_exec_pkg::word_t   lhs,
  input  rv_exec_pkg::word_t   rhs,
  output rv_exec_pkg::word_t   value
);
  import rv_exec_pkg::*;

  word_t sum;
  word_t diff;
  logic  lt_signed;
  logic  lt_unsigned;

  assign sum  = lhs + rhs;
  assign diff = lhs - rhs;

  assign lt_signed   = $signed(lhs) < $signed(rhs);
  assign lt_unsigned = lhs < rhs;

  always_comb begin
    case (funct3)
      F3_ADD_SUB: value = alt ? diff : sum;
      F3_SLT:     value = {31'b0, lt_signed};
      F3_SLTU:    value = {31'b0, lt_unsigned};
      F3_XOR:     value = lhs ^ rhs;
      F3_OR:      value = lhs | rhs;
      F3_AND:     value = lhs & rhs;
      default:    value = '0;  // Shifts go through serial_shifter
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  rv_exec_pkg::reg_idx_t rs1_idx,
  input  rv_exec_pkg::reg_idx_t rs2_idx,
  input  rv_exec_pkg::reg_idx_t wr_idx,
  input  logic                  wr_en,
  input  rv_exec_pkg::word_t    wr_data,
  output rv_exec_pkg::word_t    rs1_data,
  output rv_exec_pkg::word_t    rs2_data
);
  import rv_exec_pkg::*;

  word_t regs [NUM_REGS];

  logic rs1_ok;
  logic rs2_ok;
  logic wr_ok;

  // x0 and out-of-range indices never hit the array
  assign rs1_ok = (rs1_idx != '0) && (int'(rs1_idx) < NUM_REGS);
  assign rs2_ok = (rs2_idx != '0) && (int'(rs2_idx) < NUM_REGS);
  assign wr_ok  = wr_en && (wr_idx != '0) && (int'(wr_idx) < NUM_REGS);

  assign rs1_data = rs1_ok ? regs[rs1_idx] : '0;
  assign rs2_data = rs2_ok ? regs[rs2_idx] : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder #(
  parameter int NUM_REGS = 32
) (
  input  rv_exec_pkg::word_t    instr,
  output rv_exec_pkg::reg_idx_t rs1_idx,
  output rv_exec_pkg::reg_idx_t rs2_idx,
  output rv_exec_pkg::reg_idx_t rd_idx,
  output rv_exec_pkg::funct3_t  funct3,
  output logic                  alt,
  output rv_exec_pkg::word_t    imm,
  output logic                  is_imm,
  output logic                  is_shift,
  output logic                  illegal
);
  import rv_exec_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       is_op;
  logic       bad_opc;
  logic       bad_f7;
  logic       bad_idx;
  logic       f7_two_ok;  // funct7 is one of the two base values

  assign opcode  = instr[6:0];
  assign rd_idx  = instr[11:7];
  assign funct3  = instr[14:12];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];
  assign funct7  = instr[31:25];

  assign imm = {{20{instr[31]}}, instr[31:20]};  // I-type, sign extended

  assign is_op   = (opcode == OPC_OP);
  assign is_imm  = (opcode == OPC_OP_IMM);
  assign bad_opc = !(is_op || is_imm);

  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

  // For ADDI the bit at 30 is immediate data, not a subtract request
  assign alt = instr[30] && (is_op || funct3 == F3_SRL_SRA);

  assign f7_two_ok = (funct7 == F7_ZERO) || (funct7 == F7_ALT);

  always_comb begin
    bad_f7 = 1'b0;
    if (is_op) begin
      case (funct3)
        F3_ADD_SUB, F3_SRL_SRA: bad_f7 = !f7_two_ok;
        default:                bad_f7 = (funct7 != F7_ZERO);
      endcase
    end else if (is_imm) begin
      case (funct3)
        F3_SLL:     bad_f7 = (funct7 != F7_ZERO);
        F3_SRL_SRA: bad_f7 = !f7_two_ok;
        default:    bad_f7 = 1'b0;  // Upper bits are immediate
      endcase
    end
  end

  // rs2 only counts for register-register ops
  assign bad_idx = (int'(rd_idx) >= NUM_REGS) ||
                   (int'(rs1_idx) >= NUM_REGS) ||
                   (is_op && int'(rs2_idx) >= NUM_REGS);

  assign illegal = bad_opc || bad_f7 || bad_idx;

endmodule

`default_nettype wire

// ==== hw/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

  typedef logic [31:0] word_t;     // Operands, immediates, results
  typedef logic [4:0]  reg_idx_t;  // Register index rs1, rs2, rd
  typedef logic [2:0]  funct3_t;   // Operation selector
  typedef logic [4:0]  shamt_t;    // Shift distance

  // Major opcodes of the two supported groups
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // The two funct7 values the base ISA knows
  localparam logic [6:0] F7_ZERO = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [1:0] {
    IDLE,   // Waiting for an instruction
    SHIFT,  // Serial shift running
    DONE    // Result pulse and write-back
  } exec_state_t;

endpackage

`default_nettype wire
